// File: logic/fe_cfg.svh
// Width, buffer depth and reset address macros for the fetch front end

`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// ==============================
// Datapath widths
// ==============================

// Address and memory word width in bits
`define FE_XLEN 32

// Width of one instruction parcel, a compressed instruction fits in one
`define FE_HALF_W 16

// ==============================
// Fetch queue and reset
// ==============================

// Number of fetch queue entries, a power of two of 4 or more
`define FE_IBUF_DEPTH 8

// Address of the first fetch after reset
`define FE_RESET_PC 32'h0000_0000

`endif

// File: logic/fe_pkg.sv
// Package fe_pkg with the vector typedefs, the queue and output structs and the aligner states

`include "fe_cfg.svh"

package fe_pkg;

    // Byte address as seen on the fetch bus
    typedef logic [`FE_XLEN-1:0] addr_t;

    // One memory word as returned by the instruction memory
    typedef logic [`FE_XLEN-1:0] word_t;

    // One 16 bit instruction parcel
    typedef logic [`FE_HALF_W-1:0] half_t;

    // Queue entry: the returned word tagged with the address it was fetched from
    typedef struct packed {
        addr_t addr;
        word_t word;
    } fetch_entry_t;

    // Instruction handed to the back end, compressed parcels arrive zero-extended
    typedef struct packed {
        word_t instr;
        addr_t pc;
        logic  compressed;
    } instr_out_t;

    // EMPTY holds no parcel, HELD_UPPER holds the first half of a full instruction
    typedef enum logic {
        EMPTY,
        HELD_UPPER
    } align_state_t;

endpackage : fe_pkg

// File: logic/pc_gen.sv
// Module pc_gen with the redirect priority mux, program counter register and fetch strobe

`timescale 1ns/10ps

`include "fe_cfg.svh"

module pc_gen import fe_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,

    // Redirect requests from the back end
    input  logic  exception_i,
    input  addr_t handler_pc_i,
    input  logic  handler_return_i,
    input  addr_t return_pc_i,
    input  logic  branch_taken_i,
    input  addr_t branch_target_i,

    // Space left in the fetch queue for one more response
    input  logic  room_i,

    // Memory request and flush of everything younger than a redirect
    output logic  fetch_o,
    output addr_t fetch_addr_o,
    output logic  flush_o
);

    // Address of the most recent fetch
    addr_t pc_q;

    // Word address that follows the current pc
    addr_t next_seq_pc;

    logic redirect;

    // ==============================
    // Next address selection
    // ==============================

    // A redirect may land on a half-word, so the low bits are cleared
    // before stepping to the following word
    assign next_seq_pc = {pc_q[`FE_XLEN-1:2], 2'b00} + addr_t'(4);

    assign redirect = exception_i | handler_return_i | branch_taken_i;

    always_comb begin
        // Priority runs from trap entry down to plain sequential fetch
        if (exception_i) begin
            fetch_addr_o = handler_pc_i;
        end else if (handler_return_i) begin
            fetch_addr_o = return_pc_i;
        end else if (branch_taken_i) begin
            fetch_addr_o = branch_target_i;
        end else begin
            fetch_addr_o = next_seq_pc;
        end
    end

    // A redirect always fetches since the flush frees the whole queue
    // Nothing is fetched while reset is held
    assign fetch_o = rst_n_i & (redirect | room_i);

    // Any redirect invalidates every older word downstream
    assign flush_o = redirect;

    // ==============================
    // Program counter register
    // ==============================

    // Reset value sits one word below the reset address so the
    // sequential path produces the reset address on the first fetch
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= addr_t'(`FE_RESET_PC) - addr_t'(4);
        end else if (fetch_o) begin
            pc_q <= fetch_addr_o;
        end
    end

endmodule : pc_gen

// File: logic/fetch_queue.sv
// Module fetch_queue: pending fetch tracking, circular response buffer and room flag

`timescale 1ns/10ps

`include "fe_cfg.svh"

module fetch_queue import fe_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,

    // Request side, the address is kept until its word comes back
    input  logic         fetch_i,
    input  addr_t        fetch_addr_i,

    // Memory response, always one cycle after the request
    input  logic         mem_valid_i,
    input  word_t        mem_word_i,

    // Consumer side
    input  logic         pop_i,
    output fetch_entry_t head_o,
    output logic         not_empty_o,
    output logic         room_o
);

    localparam int DEPTH = `FE_IBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // ==============================
    // Pending request
    // ==============================

    logic  pending_valid_q;
    addr_t pending_addr_q;

    // Only one request is ever outstanding because memory answers in one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_valid_q <= 1'b0;
        end else begin
            // A redirect fetch in the flush cycle becomes the new pending one
            pending_valid_q <= fetch_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_i) begin
            pending_addr_q <= fetch_addr_i;
        end
    end

    // ==============================
    // Circular buffer
    // ==============================

    fetch_entry_t buffer_q [DEPTH];

    // Pointers carry one extra wrap bit so full and empty differ
    logic [PTR_W:0]   wr_ptr_q;
    logic [PTR_W:0]   rd_ptr_q;
    logic [PTR_W:0]   level;
    logic [PTR_W+1:0] in_flight;
    logic             write_en;

    // Words that answer a fetch issued before a flush are dropped here,
    // the check on pending also drops a stray response right after reset
    assign write_en = mem_valid_i & pending_valid_q & !flush_i;

    always_ff @(posedge clk_i) begin
        if (write_en) begin
            buffer_q[wr_ptr_q[PTR_W-1:0]].addr <= pending_addr_q;
            buffer_q[wr_ptr_q[PTR_W-1:0]].word <= mem_word_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (write_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    assign level = wr_ptr_q - rd_ptr_q;

    assign head_o      = buffer_q[rd_ptr_q[PTR_W-1:0]];
    assign not_empty_o = (level != '0);

    // Stored words plus the response still on its way must leave a free
    // slot for the word a new fetch will return
    assign in_flight = {1'b0, level} + (PTR_W+2)'(pending_valid_q);
    assign room_o    = (in_flight < (PTR_W+2)'(DEPTH));

endmodule : fetch_queue

// File: logic/instr_aligner.sv
// Module instr_align: parcel splitting, boundary-crossing assembly and the output register

`timescale 1ns/10ps

`include "fe_cfg.svh"

module instr_align import fe_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         stall_i,

    // Oldest buffered word from the fetch queue
    input  fetch_entry_t head_i,
    input  logic         not_empty_i,
    output logic         pop_o,

    // Instruction towards the back end
    output logic         instr_valid_o,
    output instr_out_t   instr_o
);

    // ==============================
    // Alignment state
    // ==============================

    align_state_t state_q;
    align_state_t state_d;

    // Set once the lower half of the head word has been consumed
    logic use_upper_q;
    logic use_upper_d;

    // First parcel of a full instruction that crosses into the next word
    half_t held_half_q;
    addr_t held_pc_q;
    logic  hold_en;

    logic       upper_sel;
    half_t      parcel;
    addr_t      parcel_pc;
    logic       parcel_full;
    logic       emit;
    instr_out_t emit_instr;
    logic       advance;

    // Nothing moves while the back end stalls or a redirect flushes
    assign advance = !stall_i & !flush_i & not_empty_i;

    // A redirect to a half-word target leaves bit 1 set in the entry address
    assign upper_sel = use_upper_q | head_i.addr[1];
    assign parcel    = upper_sel ? head_i.word[`FE_XLEN-1:`FE_HALF_W]
                                 : head_i.word[`FE_HALF_W-1:0];
    assign parcel_pc = {head_i.addr[`FE_XLEN-1:2], upper_sel, 1'b0};

    // Both low bits set marks the first parcel of a 32 bit instruction
    assign parcel_full = (parcel[1:0] == 2'b11);

    always_comb begin
        state_d     = state_q;
        use_upper_d = use_upper_q;
        emit        = 1'b0;
        pop_o       = 1'b0;
        hold_en     = 1'b0;
        emit_instr  = '{instr: head_i.word, pc: parcel_pc, compressed: 1'b0};

        if (advance) begin
            if (state_q == HELD_UPPER) begin
                // Finish the crossing instruction with this word's lower half
                emit        = 1'b1;
                emit_instr  = '{instr: {head_i.word[`FE_HALF_W-1:0], held_half_q},
                                pc: held_pc_q, compressed: 1'b0};
                state_d     = EMPTY;
                use_upper_d = 1'b1;
            end else if (!parcel_full) begin
                // Compressed parcel, leaves zero-extended
                emit        = 1'b1;
                emit_instr  = '{instr: word_t'(parcel), pc: parcel_pc, compressed: 1'b1};
                pop_o       = upper_sel;
                use_upper_d = !upper_sel;
            end else if (!upper_sel) begin
                // Full instruction that fills the whole word
                emit        = 1'b1;
                pop_o       = 1'b1;
                use_upper_d = 1'b0;
            end else begin
                // Full instruction starting in the upper half, keep it for the next word
                hold_en     = 1'b1;
                pop_o       = 1'b1;
                state_d     = HELD_UPPER;
                use_upper_d = 1'b0;
            end
        end
    end

    // ==============================
    // State and output registers
    // ==============================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q     <= EMPTY;
            use_upper_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            use_upper_q <= use_upper_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hold_en) begin
            held_half_q <= parcel;
            held_pc_q   <= parcel_pc;
        end
    end

    // A flush wins over a stall so nothing older than a redirect remains visible
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            instr_valid_o <= 1'b0;
        end else if (!stall_i) begin
            instr_valid_o <= emit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && emit) begin
            instr_o <= emit_instr;
        end
    end

endmodule : instr_align

// File: logic/fetch_front_end.sv
// Module fetch_front_end: top level chaining the PC generator, fetch queue and aligner

`timescale 1ns/10ps

module fetch_front_end import fe_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Instruction memory
    output logic       fetch_o,
    output addr_t      fetch_addr_o,
    input  logic       mem_valid_i,
    input  word_t      mem_word_i,

    // Redirects, listed from highest to lowest priority
    input  logic       exception_i,
    input  addr_t      handler_pc_i,
    input  logic       handler_return_i,
    input  addr_t      return_pc_i,
    input  logic       branch_taken_i,
    input  addr_t      branch_target_i,

    // Back end
    input  logic       stall_i,
    output logic       instr_valid_o,
    output instr_out_t instr_o
);

    logic         flush;
    logic         room;
    logic         pop;
    logic         not_empty;
    fetch_entry_t head;

    // ==============================
    // Fetch chain
    // ==============================

    pc_gen i_pc_gen (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .exception_i      ( exception_i      ),
        .handler_pc_i     ( handler_pc_i     ),
        .handler_return_i ( handler_return_i ),
        .return_pc_i      ( return_pc_i      ),
        .branch_taken_i   ( branch_taken_i   ),
        .branch_target_i  ( branch_target_i  ),
        .room_i           ( room             ),
        .fetch_o          ( fetch_o          ),
        .fetch_addr_o     ( fetch_addr_o     ),
        .flush_o          ( flush            )
    );

    // The queue sees the same strobe and address that go out to memory
    fetch_queue i_fetch_queue (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .flush_i      ( flush        ),
        .fetch_i      ( fetch_o      ),
        .fetch_addr_i ( fetch_addr_o ),
        .mem_valid_i  ( mem_valid_i  ),
        .mem_word_i   ( mem_word_i   ),
        .pop_i        ( pop          ),
        .head_o       ( head         ),
        .not_empty_o  ( not_empty    ),
        .room_o       ( room         )
    );

    instr_align i_instr_align (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .flush_i       ( flush         ),
        .stall_i       ( stall_i       ),
        .head_i        ( head          ),
        .not_empty_i   ( not_empty     ),
        .pop_o         ( pop           ),
        .instr_valid_o ( instr_valid_o ),
        .instr_o       ( instr_o       )
    );

endmodule : fetch_front_end

// File: sim/tb_clock.sv
// Module tb_clock: free running testbench clock and synchronous active-low reset

`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset is released on a rising edge, like any other synchronous input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : tb_clock

// File: sim/tb_fetch_front_end.sv
// Module tb_fetch_front_end with the memory model, reference walker, check task and directed tests

`timescale 1ns/10ps

`include "fe_cfg.svh"

module tb_fetch_front_end
    import fe_pkg::*;
();

    // Memory of 4096 half-words, so addresses wrap every 8 KB
    localparam int MEM_AW = 12;
    // The tests need roughly 600 cycles and the limit leaves a wide margin
    localparam int MAX_CYCLES = 4000;
    // Longest quiet gap allowed on the output since a redirect refill takes only a few cycles
    localparam int WAIT_LIMIT = 50;

    logic       clk;
    logic       rst_n;
    logic       fetch;
    addr_t      fetch_addr;
    logic       mem_valid = 1'b0;
    word_t      mem_word = '0;
    logic       exception;
    addr_t      handler_pc;
    logic       handler_return;
    addr_t      return_pc;
    logic       branch_taken;
    addr_t      branch_target;
    logic       stall;
    logic       instr_valid;
    instr_out_t instr;

    half_t      mem_h [2**MEM_AW];
    addr_t      ref_pc;
    instr_out_t observed [$];
    int         cycle_count = 0;

    tb_clock #(.PERIOD_NS(10.0), .RESET_CYCLES(2)) i_clock (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    fetch_front_end i_dut (
        .clk_i            ( clk            ),
        .rst_n_i          ( rst_n          ),
        .fetch_o          ( fetch          ),
        .fetch_addr_o     ( fetch_addr     ),
        .mem_valid_i      ( mem_valid      ),
        .mem_word_i       ( mem_word       ),
        .exception_i      ( exception      ),
        .handler_pc_i     ( handler_pc     ),
        .handler_return_i ( handler_return ),
        .return_pc_i      ( return_pc      ),
        .branch_taken_i   ( branch_taken   ),
        .branch_target_i  ( branch_target  ),
        .stall_i          ( stall          ),
        .instr_valid_o    ( instr_valid    ),
        .instr_o          ( instr          )
    );

    // ==============================
    // Memory, monitor and watchdog
    // ==============================

    function automatic half_t half_at(input addr_t byte_addr);
        return mem_h[byte_addr[MEM_AW:1]];
    endfunction

    // Every fetch is answered on the next cycle with its whole aligned word
    always @(posedge clk) begin
        mem_valid <= fetch;
        mem_word  <= {half_at({fetch_addr[`FE_XLEN-1:2], 2'b10}),
                      half_at({fetch_addr[`FE_XLEN-1:2], 2'b00})};
    end

    // An output counts as taken at the edge that ends an unstalled valid cycle
    always @(posedge clk) begin
        if (rst_n && instr_valid && !stall) begin
            observed.push_back(instr);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles before the tests completed", cycle_count);
            $display("Finished with errors");
            $fatal(1, "simulation timeout");
        end
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Lower halves of words forced full give a program of 32 bit instructions only
    task automatic fill_program(input logic full_only);
        half_t h;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            h = half_t'($urandom);
            if (full_only) begin
                if (i[0] == 1'b0) begin
                    h[1:0] = 2'b11;
                end
            end else if ($urandom % 2 == 32'd1) begin
                h[1:0] = 2'b11;
            end
            mem_h[i[MEM_AW-1:0]] = h;
        end
    endtask

    // Reference walk that returns one instruction per call starting at ref_pc
    task automatic next_expected(output instr_out_t exp);
        half_t first;
        first  = half_at(ref_pc);
        exp.pc = ref_pc;
        if (first[1:0] == 2'b11) begin
            exp.instr      = {half_at(ref_pc + addr_t'(2)), first};
            exp.compressed = 1'b0;
            ref_pc         = ref_pc + addr_t'(4);
        end else begin
            exp.instr      = word_t'(first);
            exp.compressed = 1'b1;
            ref_pc         = ref_pc + addr_t'(2);
        end
    endtask

    task automatic take_output(output instr_out_t got);
        int waited;
        waited = 0;
        while (observed.size() == 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("No instruction came out within %0d cycles", WAIT_LIMIT);
                $display("Finished with errors");
                $fatal(1, "output timeout");
            end
        end
        got = observed.pop_front();
    endtask

    task automatic compare_stream(input int count);
        instr_out_t got;
        instr_out_t exp;
        for (int k = 0; k < count; k++) begin
            take_output(got);
            next_expected(exp);
            check_value("instr_o.pc", got.pc, exp.pc);
            check_value("instr_o.instr", got.instr, exp.instr);
            check_value("instr_o.compressed", word_t'(got.compressed), word_t'(exp.compressed));
        end
    endtask

    // One cycle redirect pulse whose winning address must go out in that same cycle
    task automatic apply_redirect(input logic exc, input logic ret, input logic br,
                                  input addr_t handler, input addr_t ret_pc,
                                  input addr_t target, input addr_t start_pc);
        @(posedge clk);
        exception      <= exc;
        handler_return <= ret;
        branch_taken   <= br;
        handler_pc     <= handler;
        return_pc      <= ret_pc;
        branch_target  <= target;
        @(negedge clk);
        check_value("fetch_o", word_t'(fetch), 32'd1);
        check_value("fetch_addr_o", fetch_addr, start_pc);
        @(posedge clk);
        exception      <= 1'b0;
        handler_return <= 1'b0;
        branch_taken   <= 1'b0;
        // The output shown during the redirect cycle is older and gets dropped
        @(negedge clk);
        observed.delete();
        ref_pc = start_pc;
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic full_program_stream();
        // Reset holds off every fetch
        @(posedge clk);
        @(negedge clk);
        while (rst_n !== 1'b1) begin
            check_value("fetch_o", word_t'(fetch), 32'd0);
            @(negedge clk);
        end
        // The first cycle after release fetches the reset address
        check_value("fetch_o", word_t'(fetch), 32'd1);
        check_value("fetch_addr_o", fetch_addr, addr_t'(`FE_RESET_PC));
        ref_pc = addr_t'(`FE_RESET_PC);
        compare_stream(40);
    endtask

    task automatic mixed_program_stream();
        @(negedge clk);
        fill_program(1'b0);
        apply_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0000_0000, 32'h0000_0000);
        compare_stream(200);
    endtask

    task automatic branch_redirect_restart();
        compare_stream(20);
        apply_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h0000_02A6, 32'h0000_02A6);
        compare_stream(40);
    endtask

    task automatic redirect_priority_order();
        apply_redirect(1'b1, 1'b1, 1'b1, 32'h0000_0300, 32'h0000_0516, 32'h0000_070A,
                       32'h0000_0300);
        compare_stream(30);
        apply_redirect(1'b0, 1'b1, 1'b1, 32'h0000_0300, 32'h0000_0516, 32'h0000_070A,
                       32'h0000_0516);
        compare_stream(30);
    endtask

    task automatic stall_holds_output();
        instr_out_t held;
        logic       held_valid;
        compare_stream(10);
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        held       = instr;
        held_valid = instr_valid;
        repeat (29) begin
            @(negedge clk);
            check_value("instr_valid_o", word_t'(instr_valid), word_t'(held_valid));
            check_value("instr_o.pc", instr.pc, held.pc);
            check_value("instr_o.instr", instr.instr, held.instr);
            check_value("instr_o.compressed", word_t'(instr.compressed),
                        word_t'(held.compressed));
        end
        // The queue has filled by now, so fetching must have stopped
        check_value("fetch_o", word_t'(fetch), 32'd0);
        @(posedge clk);
        stall <= 1'b0;
        compare_stream(40);
    endtask

    initial begin
        exception      <= 1'b0;
        handler_pc     <= '0;
        handler_return <= 1'b0;
        return_pc      <= '0;
        branch_taken   <= 1'b0;
        branch_target  <= '0;
        stall          <= 1'b0;
        void'($urandom(53));
        fill_program(1'b1);
        full_program_stream();
        mixed_program_stream();
        branch_redirect_restart();
        redirect_priority_order();
        stall_holds_output();
        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_fetch_front_end

// File: sim.f
+incdir+logic
logic/fe_pkg.sv
logic/pc_gen.sv
logic/fetch_queue.sv
logic/instr_aligner.sv
logic/fetch_front_end.sv
sim/tb_clock.sv
sim/tb_fetch_front_end.sv

// File: run_sim.sh
#!/bin/sh
# Builds the fetch front end testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_fetch_front_end -Mdir build \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./build/Vtb_fetch_front_end > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "FAIL"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
echo "PASS"
exit 0
